/* all.f */
+incdir+tests
design/ahb_mtx_pkg.sv
design/ahb_arb_if.sv
design/ahb_mtx_arbiter.sv
design/ahb_mtx_addr_router.sv
design/ahb_mtx_data_router.sv
design/ahb_mtx_output_stage.sv
tests/tb_output_stage.sv

/* design/ahb_arb_if.sv */
//--------------------------------------------------------------------------
// Internal link of the output stage
//   Grant from the arbiter
//   Routed select, transfer type and lock from the address router
//   Ready mux from the data router
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

interface ahb_arb_if #(
  parameter int NUM_PORTS = 3                  // Number of input ports
);
  import ahb_mtx_pkg::*;

  localparam int GNT_W = $clog2(NUM_PORTS);   // Grant index width

  logic [GNT_W-1:0] grant_port;                // Granted port index
  logic             grant_valid;               // Some port holds the grant
  logic             hsel_m;                    // Routed HSEL
  htrans_t          htrans_m;                  // Routed HTRANS
  logic             hlock_arb;                 // Lock seen by the arbiter
  logic             hreadymux;                 // Shared HREADY

  modport arb  (output grant_port, grant_valid,
                input  hlock_arb, hreadymux);
  modport addr (input  grant_port, grant_valid, hreadymux,
                output hsel_m, htrans_m, hlock_arb);
  modport data (input  grant_port, grant_valid, hsel_m,
                output hreadymux);

endinterface

`default_nettype wire

/* design/ahb_mtx_addr_router.sv */
//--------------------------------------------------------------------------
// Address phase router
//   Address and control mux from the granted port
//   One-hot port active decode
//   Locked sequence tracker and arbiter lock
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module ahb_mtx_addr_router #(
  parameter int NUM_PORTS = 3                              // Input ports
) (
  input  logic                                 HCLK,       // Bus clock
  input  logic                                 HRESETn,    // Sync reset
  input  logic [NUM_PORTS-1:0]                 i_sel,      // Port HSEL
  input  ahb_mtx_pkg::haddr_t  [NUM_PORTS-1:0] i_addr,     // Port HADDR
  input  ahb_mtx_pkg::htrans_t [NUM_PORTS-1:0] i_trans,    // Port HTRANS
  input  logic [NUM_PORTS-1:0]                 i_write,    // Port HWRITE
  input  logic [NUM_PORTS-1:0]                 i_mastlock, // Port HMASTLOCK
  input  ahb_mtx_pkg::hsize_t  [NUM_PORTS-1:0] i_size,     // Port HSIZE
  output logic [NUM_PORTS-1:0]                 o_active,   // Port granted
  output ahb_mtx_pkg::haddr_t                  o_haddr,    // Slave HADDR
  output logic                                 o_hwrite,   // Slave HWRITE
  output logic                                 o_hmastlock,// Slave HMASTLOCK
  output ahb_mtx_pkg::hsize_t                  o_hsize,    // Slave HSIZE
  ahb_arb_if.addr                              arb         // Internal link
);
  import ahb_mtx_pkg::*;

  localparam int GNT_W = $clog2(NUM_PORTS);               // Index width

  logic    hsel_r;           // Routed HSEL
  htrans_t trans_r;          // Routed HTRANS
  logic    mastlock_r;       // Routed HMASTLOCK
  logic    hsel_lock;        // Lock held while HSEL drops
  logic    next_hsel_lock;   // Next hsel_lock

  //--------------------------------------------------------------------------
  // Address and control mux
  //--------------------------------------------------------------------------
  always_comb
  begin : p_addr_mux
    o_active   = '0;
    hsel_r     = 1'b0;
    o_haddr    = '0;
    trans_r    = TRANS_IDLE;                       // Idle without grant
    o_hwrite   = 1'b0;
    o_hsize    = '0;
    mastlock_r = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
      if (arb.grant_valid && arb.grant_port == GNT_W'(p))
      begin
        o_active[p] = 1'b1;                        // One-hot decode
        hsel_r      = i_sel[p];
        o_haddr     = i_addr[p];
        trans_r     = i_trans[p];
        o_hwrite    = i_write[p];
        o_hsize     = i_size[p];
        mastlock_r  = i_mastlock[p];
      end
  end

  //--------------------------------------------------------------------------
  // Locked sequence tracking
  //--------------------------------------------------------------------------
  // A master may leave this slave mid-lock, so the lock is remembered
  assign next_hsel_lock =
    (hsel_r && (trans_r == TRANS_NONSEQ || trans_r == TRANS_SEQ) && mastlock_r) ? 1'b1 :
    (!mastlock_r) ? 1'b0 : hsel_lock;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      hsel_lock <= 1'b0;
    else if (arb.hreadymux)                        // Accepted edge only
      hsel_lock <= next_hsel_lock;
  end

  assign arb.hlock_arb = mastlock_r & (hsel_lock | hsel_r); // Masked lock
  assign arb.hsel_m    = hsel_r;
  assign arb.htrans_m  = trans_r;
  assign o_hmastlock   = mastlock_r;

endmodule

`default_nettype wire

/* design/ahb_mtx_arbiter.sv */
//--------------------------------------------------------------------------
// Round-robin arbiter for the output stage
//   Request forming from HSEL and held transfer
//   Grant kept during locked sequences and bursts
//   Search for the next requester after the current grant
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module ahb_mtx_arbiter #(
  parameter int NUM_PORTS = 3                              // Input ports
) (
  input  logic                                 HCLK,       // Bus clock
  input  logic                                 HRESETn,    // Sync reset
  input  logic [NUM_PORTS-1:0]                 i_sel,      // Port HSEL
  input  logic [NUM_PORTS-1:0]                 i_held_tran,// Port has transfer
  input  ahb_mtx_pkg::htrans_t [NUM_PORTS-1:0] i_trans,    // Port HTRANS
  ahb_arb_if.arb                               arb         // Internal link
);
  import ahb_mtx_pkg::*;

  localparam int GNT_W = $clog2(NUM_PORTS);               // Index width

  logic [NUM_PORTS-1:0] req;           // Port requests
  logic [GNT_W-1:0]     grant_q;       // Current grant
  logic                 valid_q;       // Grant valid
  logic [GNT_W-1:0]     grant_d;       // Next grant
  logic                 valid_d;       // Next grant valid
  logic [GNT_W-1:0]     start_port;    // Search begins after this one
  logic [GNT_W-1:0]     next_port;     // First requester found
  logic                 found;         // Search hit
  logic                 burst_hold;    // Granted port mid-burst

  assign req = i_sel & i_held_tran;    // Request needs both

  // Last port when idle so port 0 comes first
  assign start_port = valid_q ? grant_q : GNT_W'(NUM_PORTS - 1);

  //--------------------------------------------------------------------------
  // Round-robin search
  //--------------------------------------------------------------------------
  always_comb
  begin : p_search
    int cand;                                          // Candidate port
    found     = 1'b0;
    next_port = '0;
    for (int off = 1; off <= NUM_PORTS; off++)
    begin
      cand = int'(start_port) + off;
      if (cand >= NUM_PORTS)
        cand = cand - NUM_PORTS;                       // Wrap around
      if (!found && req[cand])
      begin
        found     = 1'b1;                              // Keep first hit
        next_port = GNT_W'(cand);
      end
    end
  end

  // SEQ or BUSY on the granted port keeps the burst together
  always_comb
  begin : p_burst_hold
    burst_hold = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
      if (grant_q == GNT_W'(p) && i_sel[p] &&
          (i_trans[p] == TRANS_SEQ || i_trans[p] == TRANS_BUSY))
        burst_hold = 1'b1;
  end

  always_comb
  begin : p_next_grant
    grant_d = grant_q;                                 // Default hold
    valid_d = valid_q;
    if (valid_q && arb.hlock_arb)
      valid_d = 1'b1;                                  // Locked sequence
    else if (valid_q && burst_hold)
      valid_d = 1'b1;                                  // Burst in progress
    else if (found)
    begin
      grant_d = next_port;
      valid_d = 1'b1;
    end
    else
      valid_d = 1'b0;                                  // Nobody asks
  end

  //--------------------------------------------------------------------------
  // Grant register
  //--------------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_q <= '0;
      valid_q <= 1'b0;
    end
    else if (arb.hreadymux)                            // Accepted edge only
    begin
      grant_q <= grant_d;
      valid_q <= valid_d;
    end
  end

  assign arb.grant_port  = grant_q;
  assign arb.grant_valid = valid_q;

endmodule

`default_nettype wire

/* design/ahb_mtx_data_router.sv */
//--------------------------------------------------------------------------
// Data phase router
//   Data port and slave select registers
//   Write data mux
//   Shared HREADY generation
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module ahb_mtx_data_router #(
  parameter int NUM_PORTS = 3                              // Input ports
) (
  input  logic                                 HCLK,       // Bus clock
  input  logic                                 HRESETn,    // Sync reset
  input  ahb_mtx_pkg::hwdata_t [NUM_PORTS-1:0] i_wdata,    // Port HWDATA
  input  logic                                 i_hreadyout,// Slave HREADYOUT
  output ahb_mtx_pkg::hwdata_t                 o_hwdata,   // Slave HWDATA
  ahb_arb_if.data                              arb         // Internal link
);

  localparam int GNT_W = $clog2(NUM_PORTS);               // Index width

  logic [GNT_W-1:0] data_port;    // Port in data phase
  logic             data_valid;   // Data phase owned by a port
  logic             slave_sel;    // Slave selected in data phase

  // Address phase moves into data phase on accepted edges
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port  <= '0;
      data_valid <= 1'b0;
      slave_sel  <= 1'b0;
    end
    else if (arb.hreadymux)
    begin
      data_port  <= arb.grant_port;
      data_valid <= arb.grant_valid;
      slave_sel  <= arb.hsel_m;
    end
  end

  //--------------------------------------------------------------------------
  // Write data mux
  //--------------------------------------------------------------------------
  always_comb
  begin : p_data_mux
    o_hwdata = '0;                                 // Zero with no owner
    for (int p = 0; p < NUM_PORTS; p++)
      if (data_valid && data_port == GNT_W'(p))
        o_hwdata = i_wdata[p];
  end

  // Slave ready only counts while it owns the data phase
  assign arb.hreadymux = slave_sel ? i_hreadyout : 1'b1;

endmodule

`default_nettype wire

/* design/ahb_mtx_output_stage.sv */
//--------------------------------------------------------------------------
// AHB bus matrix output stage top level
//   Plain per-port bus ports
//   Arbiter, address router and data router instances
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module ahb_mtx_output_stage #(
  parameter int NUM_PORTS = 3                              // At least 2
) (
  input  logic                                 HCLK,       // Bus clock
  input  logic                                 HRESETn,    // Sync reset
  input  logic [NUM_PORTS-1:0]                 i_sel,      // Port HSEL
  input  logic [NUM_PORTS-1:0]                 i_held_tran,// Port has transfer
  input  ahb_mtx_pkg::haddr_t  [NUM_PORTS-1:0] i_addr,     // Port HADDR
  input  ahb_mtx_pkg::htrans_t [NUM_PORTS-1:0] i_trans,    // Port HTRANS
  input  logic [NUM_PORTS-1:0]                 i_write,    // Port HWRITE
  input  ahb_mtx_pkg::hsize_t  [NUM_PORTS-1:0] i_size,     // Port HSIZE
  input  logic [NUM_PORTS-1:0]                 i_mastlock, // Port HMASTLOCK
  input  ahb_mtx_pkg::hwdata_t [NUM_PORTS-1:0] i_wdata,    // Port HWDATA
  input  logic                                 i_hreadyout,// Slave HREADYOUT
  output logic [NUM_PORTS-1:0]                 o_active,   // Port granted
  output logic                                 o_hsel,     // Slave HSEL
  output ahb_mtx_pkg::haddr_t                  o_haddr,    // Slave HADDR
  output ahb_mtx_pkg::htrans_t                 o_htrans,   // Slave HTRANS
  output logic                                 o_hwrite,   // Slave HWRITE
  output ahb_mtx_pkg::hsize_t                  o_hsize,    // Slave HSIZE
  output logic                                 o_hmastlock,// Slave HMASTLOCK
  output ahb_mtx_pkg::hwdata_t                 o_hwdata,   // Slave HWDATA
  output logic                                 o_hreadymux // Shared HREADY
);

  ahb_arb_if #(.NUM_PORTS(NUM_PORTS)) u_arb_if ();        // Internal link

  ahb_mtx_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arbiter (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_sel       (i_sel),
    .i_held_tran (i_held_tran),
    .i_trans     (i_trans),
    .arb         (u_arb_if)
  );

  ahb_mtx_addr_router #(.NUM_PORTS(NUM_PORTS)) u_addr_router (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_sel       (i_sel),
    .i_addr      (i_addr),
    .i_trans     (i_trans),
    .i_write     (i_write),
    .i_mastlock  (i_mastlock),
    .i_size      (i_size),
    .o_active    (o_active),
    .o_haddr     (o_haddr),
    .o_hwrite    (o_hwrite),
    .o_hmastlock (o_hmastlock),
    .o_hsize     (o_hsize),
    .arb         (u_arb_if)
  );

  ahb_mtx_data_router #(.NUM_PORTS(NUM_PORTS)) u_data_router (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_wdata     (i_wdata),
    .i_hreadyout (i_hreadyout),
    .o_hwdata    (o_hwdata),
    .arb         (u_arb_if)
  );

  assign o_hsel      = u_arb_if.hsel_m;                  // Routed select
  assign o_htrans    = u_arb_if.htrans_m;                // Routed type
  assign o_hreadymux = u_arb_if.hreadymux;               // Ready to all ports

endmodule

`default_nettype wire

/* design/ahb_mtx_pkg.sv */
//--------------------------------------------------------------------------
// Shared definitions for the AHB bus matrix output stage
//   Address and write-data widths
//   Vector types for address, data, transfer type and size
//   HTRANS encoding
//--------------------------------------------------------------------------

`default_nettype none

package ahb_mtx_pkg;

  //--------------------------------------------------------------------------
  // Bus widths
  //--------------------------------------------------------------------------
  localparam int ADDR_W = 32;                  // HADDR width
  localparam int DATA_W = 32;                  // HWDATA width

  //--------------------------------------------------------------------------
  // Field types
  //--------------------------------------------------------------------------
  typedef logic [ADDR_W-1:0] haddr_t;          // Address bus
  typedef logic [DATA_W-1:0] hwdata_t;         // Write data bus
  typedef logic [1:0]        htrans_t;         // Transfer type
  typedef logic [2:0]        hsize_t;          // Transfer size

  //--------------------------------------------------------------------------
  // HTRANS codes
  //--------------------------------------------------------------------------
  localparam htrans_t TRANS_IDLE   = 2'b00;    // No transfer
  localparam htrans_t TRANS_BUSY   = 2'b01;    // Burst pause
  localparam htrans_t TRANS_NONSEQ = 2'b10;    // First beat
  localparam htrans_t TRANS_SEQ    = 2'b11;    // Burst continuation

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the output stage testbench with Verilator
# The exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_output_stage -f all.f
./obj_dir/Vtb_output_stage

/* tests/tb_model.svh */
//--------------------------------------------------------------------------
// Cycle model of the output stage for the testbench
//   Grant, lock tracker, data port and slave select state
//   Value compare task and per-cycle output checks
//--------------------------------------------------------------------------

int            m_grant;        // Modelled grant index
logic          m_valid;        // Modelled grant valid
logic          m_hsel_lock;    // Modelled lock tracker
int            m_data_port;    // Port in data phase
logic          m_data_valid;   // Data phase owned by a port
logic          m_slave_sel;    // Slave selected in data phase

function automatic logic [NP-1:0] exp_active();
  return m_valid ? (NP'(1) << m_grant) : '0;       // One-hot or none
endfunction

function automatic logic exp_ready();
  return m_slave_sel ? hreadyout : 1'b1;           // Slave only in data phase
endfunction

task automatic compare_value(input logic [63:0] got, input logic [63:0] want,
                             input string what);
  if (got !== want)
  begin
    $display("TEST FAILED");
    $fatal(1, "error at %0t: %s is %0h, expected %0h", $time, what, got, want);
  end
endtask

//--------------------------------------------------------------------------
// State update at a rising edge
//--------------------------------------------------------------------------
task automatic step_model();
  logic [NP-1:0] req;
  logic          rsel;
  logic          rlock;
  htrans_t       rtrans;
  logic          lock_arb;
  logic          keep_grant;
  int            start;
  int            cand;
  int            next_g;
  if (!hresetn)
  begin
    m_grant      = 0;
    m_valid      = 1'b0;
    m_hsel_lock  = 1'b0;
    m_data_port  = 0;
    m_data_valid = 1'b0;
    m_slave_sel  = 1'b0;
    return;
  end
  if (!exp_ready())
    return;                                        // Stalled so nothing moves
  req      = sel & held_tran;
  rsel     = m_valid && sel[m_grant];
  rlock    = m_valid && mastlock[m_grant];
  rtrans   = m_valid ? trans[m_grant] : TRANS_IDLE;
  lock_arb = rlock && (m_hsel_lock || rsel);
  start    = m_valid ? m_grant : NP - 1;           // Port 0 first when idle
  next_g   = -1;
  for (int off = 1; off <= NP; off++)
  begin
    cand = (start + off) % NP;
    if (next_g < 0 && req[cand])
      next_g = cand;                               // First requester wins
  end
  keep_grant = m_valid &&
               (lock_arb || (rsel && (rtrans == TRANS_SEQ || rtrans == TRANS_BUSY)));
  m_data_port  = m_grant;                          // Address phase to data phase
  m_data_valid = m_valid;
  m_slave_sel  = rsel;
  if (rsel && (rtrans == TRANS_NONSEQ || rtrans == TRANS_SEQ) && rlock)
    m_hsel_lock = 1'b1;
  else if (!rlock)
    m_hsel_lock = 1'b0;
  if (keep_grant)
    m_valid = 1'b1;                                // Lock or burst keeps grant
  else if (next_g >= 0)
  begin
    m_grant = next_g;
    m_valid = 1'b1;
  end
  else
    m_valid = 1'b0;                                // Nobody requests
endtask

//--------------------------------------------------------------------------
// Output checks, done before inputs change
//--------------------------------------------------------------------------
task automatic check_outputs();
  haddr_t  e_addr;
  hsize_t  e_size;
  htrans_t e_trans;
  hwdata_t e_wdata;
  e_addr  = m_valid ? addr[m_grant] : '0;
  e_size  = m_valid ? size[m_grant] : '0;
  e_trans = m_valid ? trans[m_grant] : TRANS_IDLE;
  e_wdata = m_data_valid ? wdata[m_data_port] : '0; // Previous grant's data
  compare_value(64'(o_active), 64'(exp_active()), "o_active");
  compare_value(64'(o_hsel), 64'(m_valid && sel[m_grant]), "o_hsel");
  compare_value(64'(o_haddr), 64'(e_addr), "o_haddr");
  compare_value(64'(o_htrans), 64'(e_trans), "o_htrans");
  compare_value(64'(o_hwrite), 64'(m_valid && write[m_grant]), "o_hwrite");
  compare_value(64'(o_hsize), 64'(e_size), "o_hsize");
  compare_value(64'(o_hmastlock), 64'(m_valid && mastlock[m_grant]), "o_hmastlock");
  compare_value(64'(o_hwdata), 64'(e_wdata), "o_hwdata");
  compare_value(64'(o_hreadymux), 64'(exp_ready()), "o_hreadymux");
endtask

/* tests/tb_output_stage.sv */
//--------------------------------------------------------------------------
// Testbench for the AHB bus matrix output stage
//   Clock, reset and random per-port stimulus
//   DUT instance, model stepping and timeout
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module tb_output_stage;
  import ahb_mtx_pkg::*;

  localparam int NP           = 3;                 // Input ports
  localparam int RESET_CYCLES = 10;
  localparam int RUN_CYCLES   = 2000;
  localparam int MAX_CYCLES   = RUN_CYCLES + RESET_CYCLES + 100; // Margin included

  logic                hclk;
  logic                hresetn;
  logic [NP-1:0]       sel;
  logic [NP-1:0]       held_tran;
  haddr_t  [NP-1:0]    addr;
  htrans_t [NP-1:0]    trans;
  logic [NP-1:0]       write;
  hsize_t  [NP-1:0]    size;
  logic [NP-1:0]       mastlock;
  hwdata_t [NP-1:0]    wdata;
  logic                hreadyout;
  logic [NP-1:0]       o_active;
  logic                o_hsel;
  haddr_t              o_haddr;
  htrans_t             o_htrans;
  logic                o_hwrite;
  hsize_t              o_hsize;
  logic                o_hmastlock;
  hwdata_t             o_hwdata;
  logic                o_hreadymux;
  int                  lock_left [NP];             // Remaining lock run per port
  int                  cycle_count = 0;

  `include "tb_model.svh"

  ahb_mtx_output_stage #(.NUM_PORTS(NP)) i_dut (
    .HCLK (hclk), .HRESETn (hresetn),
    .i_sel (sel), .i_held_tran (held_tran), .i_addr (addr), .i_trans (trans),
    .i_write (write), .i_size (size), .i_mastlock (mastlock), .i_wdata (wdata),
    .i_hreadyout (hreadyout), .o_active (o_active), .o_hsel (o_hsel),
    .o_haddr (o_haddr), .o_htrans (o_htrans), .o_hwrite (o_hwrite),
    .o_hsize (o_hsize), .o_hmastlock (o_hmastlock), .o_hwdata (o_hwdata),
    .o_hreadymux (o_hreadymux)
  );

  always #5 hclk = ~hclk;                          // 10 ns period

  always @(posedge hclk)
  begin
    step_model();                                  // Inputs stable since negedge
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("TEST FAILED");
      $fatal(1, "timeout: run still going after %0d cycles", MAX_CYCLES);
    end
  end

  task automatic drive_random();
    int r;
    for (int p = 0; p < NP; p++)
    begin
      sel[p]       = ($urandom_range(0, 3) != 0);
      held_tran[p] = ($urandom_range(0, 3) != 0);
      addr[p]      = $urandom();
      size[p]      = hsize_t'($urandom_range(0, 3));
      write[p]     = ($urandom_range(0, 1) != 0);
      wdata[p]     = $urandom();
      r = $urandom_range(0, 9);                    // Mostly NONSEQ and SEQ
      trans[p] = (r == 0) ? TRANS_IDLE : (r == 1) ? TRANS_BUSY :
                 (r < 6) ? TRANS_NONSEQ : TRANS_SEQ;
      if (lock_left[p] > 0)
      begin
        mastlock[p]  = 1'b1;
        lock_left[p] = lock_left[p] - 1;
      end
      else
      begin
        mastlock[p] = ($urandom_range(0, 7) == 0); // Start of a lock run
        if (mastlock[p])
          lock_left[p] = $urandom_range(2, 7);
      end
    end
    hreadyout = ($urandom_range(0, 3) != 0);       // Wait state a quarter of the time
  endtask

  initial
  begin
    void'($urandom(63784));
    hclk      = 1'b0;
    hresetn   = 1'b0;
    sel       = '0;
    held_tran = '0;
    addr      = '0;
    trans     = '0;
    write     = '0;
    size      = '0;
    mastlock  = '0;
    wdata     = '0;
    hreadyout = 1'b1;
    for (int p = 0; p < NP; p++)
      lock_left[p] = 0;
    repeat (RESET_CYCLES) @(negedge hclk);
    hresetn = 1'b1;
    @(negedge hclk);
    // Idle state out of reset, no request yet
    compare_value(64'(o_active), 64'(0), "o_active after reset");
    compare_value(64'(o_hsel), 64'(0), "o_hsel after reset");
    compare_value(64'(o_hmastlock), 64'(0), "o_hmastlock after reset");
    compare_value(64'(o_hreadymux), 64'(1), "o_hreadymux after reset");
    check_outputs();
    for (int c = 0; c < RUN_CYCLES; c++)
    begin
      drive_random();
      @(negedge hclk);
      check_outputs();                             // Before the next drive
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
